// ==== logic/prefetch_config.svh ====
`ifndef PREFETCH_CONFIG_SVH
`define PREFETCH_CONFIG_SVH

// Prefetch depth
// Bounds FIFO entries plus responses still in flight, at least 2
`define PF_DEPTH 2

// Count width, must hold the value PF_DEPTH itself
`define PF_CNT_W ($clog2(`PF_DEPTH + 1))

// Fetch address held by the controller out of reset
`define PF_BOOT_ADDR 32'h0000_0080

`endif

// ==== logic/prefetch_pkg.sv ====
`default_nettype none

package prefetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // Instruction fetch types
  //////////////////////////////////////////////////////////////////////

  // Byte address on the instruction bus
  // Low two bits are cleared before going out on OBI
  typedef logic [31:0] fetch_addr_t;

  // One instruction word as returned by the memory
  typedef logic [31:0] instr_word_t;

  // Both types are plain words, nothing here is decoded in two ways
  // The FIFO stores instr_word_t, the controller steps fetch_addr_t by 4

endpackage : prefetch_pkg

`default_nettype wire

// ==== logic/obi_fetch_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_config.svh"

module obi_fetch_port (
  input  logic                        clk,
  input  logic                        rst_i,

  // Transaction side, from the controller
  input  logic                        trans_valid_i,
  output logic                        trans_ready_o,   // Grant seen while requesting
  input  prefetch_pkg::fetch_addr_t   trans_addr_i,

  // OBI address phase
  output logic                        instr_req_o,
  input  logic                        instr_gnt_i,
  output prefetch_pkg::fetch_addr_t   instr_addr_o,

  // OBI response phase
  input  prefetch_pkg::instr_word_t   instr_rdata_i,
  input  logic                        instr_rvalid_i,

  // Response side, to FIFO and fall-through mux
  output logic                        resp_valid_o,
  output prefetch_pkg::instr_word_t   resp_rdata_o,

  output logic [`PF_CNT_W-1:0]        out_cnt_o        // Granted, not yet answered
);

  import prefetch_pkg::*;

  fetch_addr_t           addr_aligned;   // Word address sent on the bus
  logic                  addr_done;      // Address phase completes this cycle
  logic [`PF_CNT_W-1:0]  out_cnt_q;

  //////////////////////////////////////////////////////////////////////
  // Address phase
  //////////////////////////////////////////////////////////////////////

  assign addr_aligned  = {trans_addr_i[31:2], 2'b00};  // Word fetches only

  assign instr_req_o   = trans_valid_i;                // Same-cycle pass-through
  assign instr_addr_o  = addr_aligned;
  assign addr_done     = trans_valid_i & instr_gnt_i;  // Grant only counts while requesting
  assign trans_ready_o = addr_done;

  //////////////////////////////////////////////////////////////////////
  // Response phase, in order, forwarded as is
  //////////////////////////////////////////////////////////////////////

  assign resp_valid_o  = instr_rvalid_i;
  assign resp_rdata_o  = instr_rdata_i;

  // Outstanding counter, +1 per grant, -1 per rvalid
  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_cnt_q <= '0;
    end else begin
      case ({addr_done, instr_rvalid_i})
        2'b10:   out_cnt_q <= out_cnt_q + `PF_CNT_W'(1);  // New request in flight
        2'b01:   out_cnt_q <= out_cnt_q - `PF_CNT_W'(1);  // One answered
        default: out_cnt_q <= out_cnt_q;                  // Both or neither, no change
      endcase
    end
  end

  assign out_cnt_o = out_cnt_q;

endmodule : obi_fetch_port

`default_nettype wire

// ==== logic/fetch_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_config.svh"

module fetch_fifo (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        flush_i,   // Empties the FIFO for the next cycle
  input  logic                        push_i,
  input  logic                        pop_i,
  input  prefetch_pkg::instr_word_t   data_i,
  output prefetch_pkg::instr_word_t   data_o,    // Head entry
  output logic                        empty_o,
  output logic [`PF_CNT_W-1:0]        cnt_o
);

  import prefetch_pkg::*;

  localparam int PTR_W = (`PF_DEPTH > 1) ? $clog2(`PF_DEPTH) : 1;

  instr_word_t           mem [`PF_DEPTH];  // Storage, no reset needed
  logic [PTR_W-1:0]      rptr_q;
  logic [PTR_W-1:0]      wptr_q;
  logic [`PF_CNT_W-1:0]  cnt_q;

  // Wrap at PF_DEPTH-1, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`PF_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin      // Flush wins over push and pop
      rptr_q <= '0;
      wptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push_i) wptr_q <= ptr_next(wptr_q);
      if (pop_i)  rptr_q <= ptr_next(rptr_q);
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + `PF_CNT_W'(1);
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - `PF_CNT_W'(1);
      end
    end
  end

  // Data write, payload only
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) mem[wptr_q] <= data_i;
  end

  assign data_o  = mem[rptr_q];
  assign empty_o = (cnt_q == '0);
  assign cnt_o   = cnt_q;

endmodule : fetch_fifo

`default_nettype wire

// ==== logic/prefetch_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_config.svh"

module prefetch_controller (
  input  logic                        clk,
  input  logic                        rst_i,

  // Core side
  input  logic                        req_i,          // Fetching allowed
  input  logic                        branch_i,       // One-cycle pulse
  input  prefetch_pkg::fetch_addr_t   branch_addr_i,
  input  logic                        fetch_ready_i,
  output logic                        fetch_valid_o,
  output logic                        busy_o,

  // Transaction request to the OBI port
  output logic                        trans_valid_o,
  input  logic                        trans_ready_i,  // Request granted this cycle
  output prefetch_pkg::fetch_addr_t   trans_addr_o,

  // Responses and outstanding count from the OBI port
  input  logic                        resp_valid_i,
  input  logic [`PF_CNT_W-1:0]        out_cnt_i,

  // FIFO control and status
  output logic                        fifo_push_o,
  output logic                        fifo_pop_o,
  output logic                        fifo_flush_o,
  input  logic [`PF_CNT_W-1:0]        fifo_cnt_i,
  input  logic                        fifo_empty_i
);

  import prefetch_pkg::*;

  fetch_addr_t           addr_q;          // Next sequential fetch address
  fetch_addr_t           branch_aligned;
  logic [`PF_CNT_W-1:0]  drop_cnt_q;      // Stale responses still to discard
  logic [`PF_CNT_W-1:0]  fifo_cnt_eff;    // FIFO count after this cycle's flush
  logic [`PF_CNT_W:0]    credit_used;     // One extra bit, sum may pass PF_DEPTH
  logic                  credit_ok;
  logic                  resp_drop;
  logic                  fall_through;

  //////////////////////////////////////////////////////////////////////
  // Credits and request
  //////////////////////////////////////////////////////////////////////

  assign branch_aligned = {branch_addr_i[31:2], 2'b00};
  assign fifo_cnt_eff   = branch_i ? '0 : fifo_cnt_i;   // Branch flushes the FIFO
  assign credit_used    = {1'b0, out_cnt_i} + {1'b0, fifo_cnt_eff};
  assign credit_ok      = (credit_used < (`PF_CNT_W + 1)'(`PF_DEPTH));

  // Every response finds room since in flight plus stored stays <= PF_DEPTH
  assign trans_valid_o  = req_i & credit_ok;
  assign trans_addr_o   = branch_i ? branch_aligned : addr_q;  // Redirect in same cycle

  //////////////////////////////////////////////////////////////////////
  // Response routing
  //////////////////////////////////////////////////////////////////////

  assign resp_drop     = branch_i | (drop_cnt_q != '0);   // Stale or racing the branch
  assign fall_through  = resp_valid_i & ~resp_drop & fifo_empty_i & fetch_ready_i;

  assign fetch_valid_o = (~branch_i & ~fifo_empty_i) |    // Head of FIFO first
                         (resp_valid_i & ~resp_drop);     // Else live response
  assign fifo_pop_o    = ~branch_i & ~fifo_empty_i & fetch_ready_i;
  assign fifo_push_o   = resp_valid_i & ~resp_drop & ~fall_through;
  assign fifo_flush_o  = branch_i;

  assign busy_o        = (out_cnt_i != '0) | (drop_cnt_q != '0);

  //////////////////////////////////////////////////////////////////////
  // Address and drop counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      addr_q     <= `PF_BOOT_ADDR;
      drop_cnt_q <= '0;
    end else begin
      if (branch_i) begin
        addr_q <= trans_ready_i ? branch_aligned + 32'd4 : branch_aligned;
      end else if (trans_ready_i) begin
        addr_q <= addr_q + 32'd4;                // Step to next word
      end

      if (branch_i) begin
        // Everything in flight is stale, minus the one ending now
        drop_cnt_q <= out_cnt_i - `PF_CNT_W'(resp_valid_i);
      end else if (resp_valid_i && (drop_cnt_q != '0)) begin
        drop_cnt_q <= drop_cnt_q - `PF_CNT_W'(1);
      end
    end
  end

endmodule : prefetch_controller

`default_nettype wire

// ==== logic/prefetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_config.svh"

module prefetch_buffer (
  input  logic                        clk,
  input  logic                        rst_i,

  input  logic                        req_i,
  input  logic                        branch_i,
  input  prefetch_pkg::fetch_addr_t   branch_addr_i,

  input  logic                        fetch_ready_i,
  output logic                        fetch_valid_o,
  output prefetch_pkg::instr_word_t   fetch_rdata_o,

  // Instruction memory, OBI
  output logic                        instr_req_o,
  input  logic                        instr_gnt_i,
  output prefetch_pkg::fetch_addr_t   instr_addr_o,
  input  prefetch_pkg::instr_word_t   instr_rdata_i,
  input  logic                        instr_rvalid_i,

  output logic                        busy_o
);

  import prefetch_pkg::*;

  logic                  trans_valid;
  logic                  trans_ready;
  fetch_addr_t           trans_addr;
  logic                  resp_valid;
  instr_word_t           resp_rdata;
  instr_word_t           fifo_rdata;
  logic                  fifo_push, fifo_pop, fifo_flush;
  logic                  fifo_empty;
  logic [`PF_CNT_W-1:0]  fifo_cnt;
  logic [`PF_CNT_W-1:0]  out_cnt;

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  obi_fetch_port obi_fetch_port_i (
    .clk (clk), .rst_i (rst_i),
    .trans_valid_i (trans_valid), .trans_ready_o (trans_ready), .trans_addr_i (trans_addr),
    .instr_req_o (instr_req_o), .instr_gnt_i (instr_gnt_i), .instr_addr_o (instr_addr_o),
    .instr_rdata_i (instr_rdata_i), .instr_rvalid_i (instr_rvalid_i),
    .resp_valid_o (resp_valid), .resp_rdata_o (resp_rdata), .out_cnt_o (out_cnt)
  );

  fetch_fifo fetch_fifo_i (
    .clk (clk), .rst_i (rst_i), .flush_i (fifo_flush), .push_i (fifo_push), .pop_i (fifo_pop),
    .data_i (resp_rdata), .data_o (fifo_rdata), .empty_o (fifo_empty), .cnt_o (fifo_cnt)
  );

  prefetch_controller prefetch_controller_i (
    .clk (clk), .rst_i (rst_i),
    .req_i (req_i), .branch_i (branch_i), .branch_addr_i (branch_addr_i),
    .fetch_ready_i (fetch_ready_i), .fetch_valid_o (fetch_valid_o), .busy_o (busy_o),
    .trans_valid_o (trans_valid), .trans_ready_i (trans_ready), .trans_addr_o (trans_addr),
    .resp_valid_i (resp_valid), .out_cnt_i (out_cnt),
    .fifo_push_o (fifo_push), .fifo_pop_o (fifo_pop), .fifo_flush_o (fifo_flush),
    .fifo_cnt_i (fifo_cnt), .fifo_empty_i (fifo_empty)
  );

  // Head of FIFO when it holds data, otherwise the live response
  assign fetch_rdata_o = fifo_empty ? resp_rdata : fifo_rdata;

endmodule : prefetch_buffer

`default_nettype wire

// ==== testbench/instr_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem_model (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic [31:0]                rnd_i,          // Fresh random word every cycle
  input  logic                       instr_req_i,
  input  prefetch_pkg::fetch_addr_t  instr_addr_i,
  output logic                       instr_gnt_o,
  output prefetch_pkg::instr_word_t  instr_rdata_o,
  output logic                       instr_rvalid_o
);

  import prefetch_pkg::*;

  instr_word_t  data_q [$];       // Granted words, not yet answered
  int           due_q  [$];       // Earliest answer cycle per word
  int           cycle;
  int           gnt_wait;         // Stall cycles left before the next grant
  int           last_due;
  logic         gnt_q    = 1'b0;
  logic         rvalid_q = 1'b0;
  instr_word_t  rdata_q  = '0;

  assign instr_gnt_o    = gnt_q;
  assign instr_rvalid_o = rvalid_q;
  assign instr_rdata_o  = rdata_q;

  // Address phase and response retire, on the rising edge
  always @(posedge clk) begin : accept
    int due;
    if (rst_i) begin
      data_q.delete();
      due_q.delete();
      cycle    = 0;
      gnt_wait = 0;
      last_due = 0;
    end else begin
      if (rvalid_q) begin                               // Head went out this cycle
        void'(data_q.pop_front());
        void'(due_q.pop_front());
      end
      if (instr_req_i && gnt_q) begin
        due = cycle + 1 + int'(rnd_i[25:24]) % 3;       // 1 to 3 cycles after grant
        if (due <= last_due) due = last_due + 1;        // In order, one per cycle
        data_q.push_back(({2'b00, instr_addr_i[31:2]} ^ 32'hA5A5_0000) +
                         {instr_addr_i[15:0], instr_addr_i[31:16]});
        due_q.push_back(due);
        last_due = due;
        gnt_wait = int'(rnd_i[29:28]) % 3;              // Next grant after 0 to 2
      end else if (instr_req_i && gnt_wait > 0) begin
        gnt_wait--;                                     // Stall counts only while asked
      end
      cycle++;
    end
  end

  // Grant and response outputs move on the falling edge
  always @(negedge clk) begin
    rvalid_q = 1'b0;
    if (due_q.size() != 0) rvalid_q = (due_q[0] <= cycle);
    rdata_q  = rvalid_q ? data_q[0] : '0;
    gnt_q    = (gnt_wait == 0);
  end

endmodule : instr_mem_model

`default_nettype wire

// ==== testbench/prefetch_buffer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_config.svh"

module prefetch_buffer_tb;

  import prefetch_pkg::*;

  logic         clk = 1'b0;
  logic         rst_i, req_i, branch_i;
  logic         fetch_valid_o, instr_req_o, instr_gnt_i, instr_rvalid_i, busy_o;
  logic         fetch_ready_i = 1'b1;
  logic         rand_ready    = 1'b0;     // Random back-pressure on
  fetch_addr_t  branch_addr_i, instr_addr_o, exp_addr;
  instr_word_t  fetch_rdata_o, instr_rdata_i, hold_data;
  logic [31:0]  bus_rng  = 32'd60781;     // Memory delays and ready
  logic [31:0]  stim_rng = 32'd60781;     // Branch points and targets
  logic [31:0]  mem_rnd  = '0;
  logic         hold_q;
  int           checks, errors, base;     // Main process
  int           mon_checks, mon_errors, xfers;
  int           pending;                  // Granted on the bus, not yet answered

  prefetch_buffer prefetch_buffer_i (
    .clk (clk), .rst_i (rst_i), .req_i (req_i), .branch_i (branch_i),
    .branch_addr_i (branch_addr_i), .fetch_ready_i (fetch_ready_i),
    .fetch_valid_o (fetch_valid_o), .fetch_rdata_o (fetch_rdata_o),
    .instr_req_o (instr_req_o), .instr_gnt_i (instr_gnt_i), .instr_addr_o (instr_addr_o),
    .instr_rdata_i (instr_rdata_i), .instr_rvalid_i (instr_rvalid_i), .busy_o (busy_o)
  );

  instr_mem_model instr_mem_model_i (
    .clk (clk), .rst_i (rst_i), .rnd_i (mem_rnd),
    .instr_req_i (instr_req_o), .instr_addr_i (instr_addr_o), .instr_gnt_o (instr_gnt_i),
    .instr_rdata_o (instr_rdata_i), .instr_rvalid_o (instr_rvalid_i)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word index XOR tag, plus address with its halves swapped
  function automatic instr_word_t expected_word(input fetch_addr_t addr);
    return ((addr >> 2) ^ 32'hA5A5_0000) + {addr[15:0], addr[31:16]};
  endfunction

  initial begin
    forever #50 clk = ~clk;
  end

  always @(negedge clk) begin
    bus_rng       = lcg_next(bus_rng);
    mem_rnd       = bus_rng;
    fetch_ready_i = rand_ready ? (bus_rng[27] | bus_rng[22]) : 1'b1;  // About 3 in 4
  end

  //////////////////////////////////////////////////////////////////////
  // Compare process, sampled on the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_i) begin
      exp_addr = `PF_BOOT_ADDR;
      hold_q   = 1'b0;
      pending  = 0;
    end else begin
      mon_checks++;                                   // Busy while the bus owes answers
      assert (busy_o == (pending != 0)) else begin
        mon_errors++;
        $display("ERROR at %0t: busy_o is %b with %0d responses outstanding", $time,
                 busy_o, pending);
      end
      if (instr_req_o && instr_gnt_i) pending++;
      if (instr_rvalid_i) pending--;
      if (hold_q && !branch_i) begin                  // Stalled word must stay put
        mon_checks++;
        assert (fetch_valid_o && fetch_rdata_o == hold_data) else begin
          mon_errors++;
          $display("ERROR at %0t: stalled word %h dropped or changed to %h", $time,
                   hold_data, fetch_rdata_o);
        end
      end
      if (branch_i) begin
        exp_addr = {branch_addr_i[31:2], 2'b00};      // Restart at aligned target
      end else if (fetch_valid_o && fetch_ready_i) begin
        mon_checks++;
        assert (fetch_rdata_o == expected_word(exp_addr)) else begin
          mon_errors++;
          $display("ERROR at %0t: word for %h is %h, expected %h", $time, exp_addr,
                   fetch_rdata_o, expected_word(exp_addr));
        end
        exp_addr = exp_addr + 32'd4;
        xfers++;
      end
      hold_q    = fetch_valid_o && !fetch_ready_i && !branch_i;
      hold_data = fetch_rdata_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic wait_transfers(input int n, input string what);
    int target;
    int cycles;
    target = xfers + n;
    cycles = 0;
    while (xfers < target && cycles < 50 * n + 100) begin
      @(negedge clk);
      cycles++;
    end
    if (xfers < target) begin
      errors++;
      $display("Timeout: %s stalled, %0d of %0d words came", what, n - (target - xfers), n);
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while ((busy_o || fetch_valid_o) && cycles < 200) begin
      @(posedge clk);
      cycles++;
    end
    if (busy_o || fetch_valid_o) begin
      errors++;
      $display("Timeout: buffer still busy or holding words after req_i dropped");
    end
    @(negedge clk);
  endtask

  task automatic check_quiet(input int cycles, input string what);
    repeat (cycles) begin
      @(posedge clk);
      checks++;
      assert (!instr_req_o && !fetch_valid_o && !busy_o) else begin
        errors++;
        $display("ERROR at %0t: %s, req %b valid %b busy %b", $time, what,
                 instr_req_o, fetch_valid_o, busy_o);
      end
    end
    @(negedge clk);                                   // Back on the drive edge
  endtask

  task automatic pulse_branch(input fetch_addr_t target);
    branch_i      = 1'b1;
    branch_addr_i = target;
    @(negedge clk);
    branch_i      = 1'b0;
  endtask

  task automatic report_test(input string name);
    $display("Test %s done, %0d errors", name, errors + mon_errors - base);
    base = errors + mon_errors;
  endtask

  initial begin
    rst_i         = 1'b1;
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    repeat (4) @(negedge clk);                        // Four reset cycles
    rst_i = 1'b0;
    check_quiet(8, "activity with req_i low");
    report_test("idle");

    req_i = 1'b1;                                     // Ready held high
    wait_transfers(64, "sequential fetch");
    report_test("sequential");

    @(posedge clk);
    rand_ready = 1'b1;
    wait_transfers(100, "fetch under back-pressure");
    report_test("back-pressure");

    for (int i = 0; i < 16; i++) begin
      stim_rng = lcg_next(stim_rng);
      repeat (int'(stim_rng[18:16])) @(negedge clk);  // Often with words in flight
      stim_rng = lcg_next(stim_rng);
      pulse_branch({16'h0000, stim_rng[31:16]});      // Unaligned targets too
      wait_transfers(2 + i % 3, "fetch after branch");
    end
    report_test("branches");

    @(posedge clk);
    rand_ready = 1'b0;
    @(negedge clk);
    req_i = 1'b0;
    wait_drained();
    check_quiet(8, "activity after drain");
    report_test("drain");

    $display("Checks %0d, errors %0d", checks + mon_checks, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : prefetch_buffer_tb

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/prefetch_pkg.sv
logic/obi_fetch_port.sv
logic/fetch_fifo.sv
logic/prefetch_controller.sv
logic/prefetch_buffer.sv
testbench/instr_mem_model.sv
testbench/prefetch_buffer_tb.sv

// ==== Makefile ====
BIN  := obj_dir/Vprefetch_buffer_tb
SRCS := $(filter-out +incdir+%,$(shell cat sim.f)) logic/prefetch_config.svh

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "ALL CHECKS PASSED"

$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module prefetch_buffer_tb \
	  -o Vprefetch_buffer_tb

clean:
	rm -rf obj_dir
